//--- files.f
hdl/soc_pkg.sv
hdl/uart_rx.sv
hdl/prog_loader.sv
hdl/main_ram.sv
hdl/ram_wait_gen.sv
hdl/iomem_router.sv
hdl/soc_mem_subsystem.sv
dv/tb_clk_gen.sv
dv/tb_soc_mem_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_mem_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(wildcard hdl/*.sv dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_soc_mem_subsystem.sv
`timescale 1ns/10ps

module tb_soc_mem_subsystem;

  localparam int RAM_DEPTH    = 4096;
  localparam int RAM_DELAY    = 16;
  localparam int CLKS_PER_BIT = 8;
  localparam int N_PROG       = 8;
  localparam int N_STRB       = 6;
  localparam int N_RAND       = 4;
  localparam int N_UNMAPPED   = 2;
  localparam int N_BYTES      = 4 * (N_PROG + 1);
  // Held back-pressure access counted as two
  localparam int N_ACCESS = N_PROG + 2 * N_STRB + 3 * N_RAND + 3 + 3 * N_UNMAPPED + 2;
  localparam int TIMEOUT_CYCLES =
    2 * (N_BYTES * 10 * CLKS_PER_BIT + N_ACCESS * (RAM_DELAY + 4));
  localparam int SEED = 32'h453c_065d;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] merged;
  } strb_wr_t;

  //////////////////////////////////////////////////
  // Stimulus tables
  //////////////////////////////////////////////////

  localparam logic [31:0] PROG_WORDS [N_PROG] = '{
    32'h0000_0013, 32'h1234_5678, 32'hdead_beef, 32'hcafe_f00d,
    32'h0102_0304, 32'h8bad_f00d, 32'hffff_0000, 32'ha5a5_5a5a
  };

  // Merged word is the old word with only the strobed lanes replaced
  localparam strb_wr_t STRB_TABLE [N_STRB] = '{
    '{32'h4000_0004, 32'haabb_ccdd, 4'b0001, 32'h1234_56dd},
    '{32'h4000_0008, 32'h1122_3344, 4'b1100, 32'h1122_beef},
    '{32'h4000_000c, 32'h0000_0000, 4'b1111, 32'h0000_0000},
    '{32'h4000_0010, 32'h99aa_bbcc, 4'b0110, 32'h01aa_bb04},
    '{32'h4000_0018, 32'h7777_7777, 4'b1010, 32'h77ff_7700},
    '{32'h4000_0004, 32'h0000_ee00, 4'b0010, 32'h1234_eedd}
  };

  // Unmapped addresses and the RAM word each one would alias onto
  localparam logic [31:0] UNMAPPED_ADDR [N_UNMAPPED] = '{32'h5000_0000, 32'h4010_0008};
  localparam logic [31:0] ALIAS_ADDR [N_UNMAPPED]    = '{32'h4000_0000, 32'h4000_0008};
  localparam logic [31:0] ALIAS_WORD [N_UNMAPPED]    = '{32'h0000_0013, 32'h1122_beef};

  logic                       clk;
  logic                       rst_n;
  logic                       program_rx;
  logic                       mem_valid;
  logic [soc_pkg::STRB_W-1:0] mem_wstrb;
  logic [soc_pkg::ADDR_W-1:0] mem_addr;
  logic [soc_pkg::DATA_W-1:0] mem_wdata;
  logic                       mem_ready;
  logic [soc_pkg::DATA_W-1:0] mem_rdata;
  logic                       prog_mode_led;
  logic                       sys_rst_n;

  int          errors;
  int          cycle_cnt;
  int          cycles;
  logic [31:0] rdata;
  logic [31:0] t_first;
  logic [31:0] t_second;
  logic [31:0] addr;
  logic [31:0] old_word;
  logic [31:0] new_word;
  logic [3:0]  strb;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(5)) u_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  soc_mem_subsystem #(
    .RAM_DEPTH   (RAM_DEPTH),
    .RAM_DELAY   (RAM_DELAY),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) DUT (
    .clk_i          (clk),
    .rst_n          (rst_n),
    .program_rx_i   (program_rx),
    .mem_valid_i    (mem_valid),
    .mem_wstrb_i    (mem_wstrb),
    .mem_addr_i     (mem_addr),
    .mem_wdata_i    (mem_wdata),
    .mem_ready_o    (mem_ready),
    .mem_rdata_o    (mem_rdata),
    .prog_mode_led_o(prog_mode_led),
    .sys_rst_n_o    (sys_rst_n)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Each strobe bit widened to a byte mask
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  lanes);
    logic [31:0] mask;
    mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // 8N1 frame sent LSB first at CLKS_PER_BIT clocks per bit
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      program_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic send_word(input logic [31:0] word);
    for (int i = 0; i < 4; i++) begin
      send_byte(word[8*i +: 8]);
    end
  endtask

  // Cycles counted from the valid cycle to the ready cycle
  task automatic bus_access(input logic [31:0] a, input logic [31:0] wdata,
                            input logic [3:0] lanes, output logic [31:0] rd,
                            output int n_cycles);
    @(posedge clk);
    #2;
    mem_valid = 1'b1;
    mem_addr  = a;
    mem_wdata = wdata;
    mem_wstrb = lanes;
    n_cycles  = 0;
    @(negedge clk);
    while (mem_ready !== 1'b1) begin
      n_cycles++;
      @(negedge clk);
    end
    rd = mem_rdata;
    @(posedge clk);
    #2;
    mem_valid = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic ram_access(input logic [31:0] a, input logic [31:0] wdata,
                            input logic [3:0] lanes, output logic [31:0] rd);
    int n_cycles;
    bus_access(a, wdata, lanes, rd, n_cycles);
    if (n_cycles != RAM_DELAY + 1) begin
      errors++;
      $display("Fail %0t: RAM access at %h took %0d cycles, expected %0d",
               $time, a, n_cycles, RAM_DELAY + 1);
    end
    @(negedge clk);
    // Wait-state line flushed by the handshake
    if (DUT.ram_ready !== 1'b0) begin
      errors++;
      $display("Fail %0t: RAM ready still high after handshake at %h", $time, a);
    end
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
             TIMEOUT_CYCLES, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    program_rx = 1'b1;
    mem_valid  = 1'b0;
    mem_wstrb  = '0;
    mem_addr   = '0;
    mem_wdata  = '0;
    errors     = 0;
    void'($urandom(SEED));

    // Idle state after reset
    wait (rst_n === 1'b1);
    @(negedge clk);
    if (mem_ready !== 1'b0 || prog_mode_led !== 1'b0 || sys_rst_n !== 1'b1) begin
      errors++;
      $display("Fail %0t: after reset ready=%b led=%b sys_rst_n=%b", $time,
               mem_ready, prog_mode_led, sys_rst_n);
    end

    // Program load with a bus access held against the loader
    fork
      begin
        send_word(32'(N_PROG));
        for (int i = 0; i < N_PROG; i++) begin
          send_word(PROG_WORDS[i]);
        end
      end
      begin
        wait (prog_mode_led === 1'b1);
        @(negedge clk);
        if (sys_rst_n !== 1'b0) begin
          errors++;
          $display("Fail %0t: sys_rst_n high while loading", $time);
        end
        @(posedge clk);
        #2;
        mem_valid = 1'b1;
        mem_addr  = soc_pkg::TIMER_LO_ADDR;
        mem_wstrb = '0;
        repeat (20) begin
          @(negedge clk);
          if (mem_ready !== 1'b0) begin
            errors++;
            $display("Fail %0t: bus ready seen during load", $time);
          end
        end
        @(posedge clk);
        #2;
        mem_valid = 1'b0;
      end
    join
    while (prog_mode_led !== 1'b0) begin
      @(negedge clk);
    end
    if (sys_rst_n !== 1'b1) begin
      errors++;
      $display("Fail %0t: sys_rst_n low after load", $time);
    end

    for (int i = 0; i < N_PROG; i++) begin
      ram_access(soc_pkg::RAM_BASE_ADDR + 32'(4 * i), '0, '0, rdata);
      compare_word("loaded word", rdata, PROG_WORDS[i]);
    end

    // Byte-strobe writes from the table
    for (int i = 0; i < N_STRB; i++) begin
      ram_access(STRB_TABLE[i].addr, STRB_TABLE[i].data, STRB_TABLE[i].strb, rdata);
      ram_access(STRB_TABLE[i].addr, '0, '0, rdata);
      compare_word("strobe write", rdata, STRB_TABLE[i].merged);
    end

    // Random words in a spare region
    for (int i = 0; i < N_RAND; i++) begin
      addr     = soc_pkg::RAM_BASE_ADDR + 32'(4 * (16 + i));
      old_word = $urandom;
      new_word = $urandom;
      strb     = 4'($urandom);
      ram_access(addr, old_word, 4'b1111, rdata);
      ram_access(addr, new_word, strb, rdata);
      ram_access(addr, '0, '0, rdata);
      compare_word("random strobe write", rdata, merge_lanes(old_word, new_word, strb));
    end

    // Timer answers at once and counts up
    bus_access(soc_pkg::TIMER_LO_ADDR, '0, '0, t_first, cycles);
    if (cycles != 0) begin
      errors++;
      $display("Fail %0t: timer low read took %0d cycles", $time, cycles);
    end
    bus_access(soc_pkg::TIMER_LO_ADDR, '0, '0, t_second, cycles);
    if (t_second <= t_first) begin
      errors++;
      $display("Fail %0t: timer went from %h to %h", $time, t_first, t_second);
    end
    bus_access(soc_pkg::TIMER_HI_ADDR, '0, '0, rdata, cycles);
    if (cycles != 0) begin
      errors++;
      $display("Fail %0t: timer high read took %0d cycles", $time, cycles);
    end
    compare_word("timer high", rdata, '0);

    // Unmapped accesses leave the aliased RAM word intact
    for (int i = 0; i < N_UNMAPPED; i++) begin
      bus_access(UNMAPPED_ADDR[i], 32'hffff_ffff, 4'b1111, rdata, cycles);
      if (cycles != 0) begin
        errors++;
        $display("Fail %0t: unmapped write took %0d cycles", $time, cycles);
      end
      bus_access(UNMAPPED_ADDR[i], '0, '0, rdata, cycles);
      if (cycles != 0) begin
        errors++;
        $display("Fail %0t: unmapped read took %0d cycles", $time, cycles);
      end
      compare_word("unmapped", rdata, '0);
      ram_access(ALIAS_ADDR[i], '0, '0, rdata);
      compare_word("aliased RAM word", rdata, ALIAS_WORD[i]);
    end

    $display("Run finished after %0d cycles with %0d errors", cycle_cnt, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // Released just after an edge, like the rest of the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

//--- hdl/soc_mem_subsystem.sv
`timescale 1ns/10ps

module soc_mem_subsystem #(
  parameter int RAM_DEPTH    = 4096,
  parameter int RAM_DELAY    = 16,
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                       clk_i,
  input  logic                       rst_n,
  input  logic                       program_rx_i,
  input  logic                       mem_valid_i,
  input  logic [soc_pkg::STRB_W-1:0] mem_wstrb_i,
  input  logic [soc_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] mem_wdata_i,
  output logic                       mem_ready_o,
  output logic [soc_pkg::DATA_W-1:0] mem_rdata_o,
  output logic                       prog_mode_led_o,
  output logic                       sys_rst_n_o
);

  localparam int AW = $clog2(RAM_DEPTH);

  logic [soc_pkg::BYTE_W-1:0] rx_byte;
  logic                       rx_strobe;
  logic                       ld_active;
  logic                       ld_we;
  logic [AW-1:0]              ld_addr;
  logic [soc_pkg::DATA_W-1:0] ld_wdata;
  logic [AW-1:0]              ram_addr;
  logic [soc_pkg::DATA_W-1:0] ram_wdata;
  logic [soc_pkg::STRB_W-1:0] ram_wstrb;
  logic                       ram_rd_en;
  logic [soc_pkg::DATA_W-1:0] ram_rdata;
  logic                       ram_req;
  logic                       ram_done;
  logic                       ram_ready;

  // Processor held in reset for the whole load
  assign sys_rst_n_o     = rst_n && !ld_active;
  assign prog_mode_led_o = ld_active;

  //////////////////////////////////////////////////
  // Program loader path
  //////////////////////////////////////////////////

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .rx_i    (program_rx_i),
    .byte_o  (rx_byte),
    .strobe_o(rx_strobe)
  );

  prog_loader #(.RAM_DEPTH(RAM_DEPTH)) u_prog_loader (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .byte_i  (rx_byte),
    .strobe_i(rx_strobe),
    .active_o(ld_active),
    .we_o    (ld_we),
    .addr_o  (ld_addr),
    .wdata_o (ld_wdata)
  );

  //////////////////////////////////////////////////
  // Bus fabric and memory
  //////////////////////////////////////////////////

  iomem_router #(.RAM_DEPTH(RAM_DEPTH)) u_iomem_router (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .valid_i    (mem_valid_i),
    .wstrb_i    (mem_wstrb_i),
    .addr_i     (mem_addr_i),
    .wdata_i    (mem_wdata_i),
    .ready_o    (mem_ready_o),
    .rdata_o    (mem_rdata_o),
    .ld_active_i(ld_active),
    .ld_we_i    (ld_we),
    .ld_addr_i  (ld_addr),
    .ld_wdata_i (ld_wdata),
    .ram_addr_o (ram_addr),
    .ram_wdata_o(ram_wdata),
    .ram_wstrb_o(ram_wstrb),
    .ram_rd_en_o(ram_rd_en),
    .ram_rdata_i(ram_rdata),
    .ram_req_o  (ram_req),
    .ram_done_o (ram_done),
    .ram_ready_i(ram_ready)
  );

  main_ram #(.RAM_DEPTH(RAM_DEPTH)) u_main_ram (
    .clk_i  (clk_i),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .wstrb_i(ram_wstrb),
    .rd_en_i(ram_rd_en),
    .rdata_o(ram_rdata)
  );

  ram_wait_gen #(.RAM_DELAY(RAM_DELAY)) u_ram_wait_gen (
    .clk_i  (clk_i),
    .rst_n  (rst_n),
    .req_i  (ram_req),
    .done_i (ram_done),
    .ready_o(ram_ready)
  );

endmodule

//--- hdl/iomem_router.sv
`timescale 1ns/10ps

module iomem_router #(
  parameter int RAM_DEPTH = 4096
) (
  input  logic                         clk_i,
  input  logic                         rst_n,
  input  logic                         valid_i,
  input  logic [soc_pkg::STRB_W-1:0]   wstrb_i,
  input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic                         ready_o,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  input  logic                         ld_active_i,
  input  logic                         ld_we_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] ld_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   ld_wdata_i,
  output logic [$clog2(RAM_DEPTH)-1:0] ram_addr_o,
  output logic [soc_pkg::DATA_W-1:0]   ram_wdata_o,
  output logic [soc_pkg::STRB_W-1:0]   ram_wstrb_o,
  output logic                         ram_rd_en_o,
  input  logic [soc_pkg::DATA_W-1:0]   ram_rdata_i,
  output logic                         ram_req_o,
  output logic                         ram_done_o,
  input  logic                         ram_ready_i
);

  localparam int AW      = $clog2(RAM_DEPTH);
  localparam int TIMER_W = 2 * soc_pkg::DATA_W;

  logic               is_ram;
  logic               is_timer_lo;
  logic               is_timer_hi;
  logic               bus_en;
  logic [TIMER_W-1:0] timer_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign is_ram      = (addr_i & ~soc_pkg::RAM_MASK_ADDR) == soc_pkg::RAM_BASE_ADDR;
  assign is_timer_lo = addr_i == soc_pkg::TIMER_LO_ADDR;
  assign is_timer_hi = addr_i == soc_pkg::TIMER_HI_ADDR;

  // Loader owns the RAM, bus sees back-pressure
  assign bus_en = valid_i && !ld_active_i;

  // Timer and unmapped answer at once, RAM waits for the delay line
  assign ready_o    = bus_en && (is_ram ? ram_ready_i : 1'b1);
  assign ram_req_o  = bus_en && is_ram && !ram_ready_i;
  assign ram_done_o = bus_en && is_ram && ram_ready_i;

  assign rdata_o = is_timer_lo ? timer_q[soc_pkg::DATA_W-1:0] :
                   is_timer_hi ? timer_q[TIMER_W-1:soc_pkg::DATA_W] :
                   is_ram      ? ram_rdata_i : '0;

  //////////////////////////////////////////////////
  // RAM port mux
  //////////////////////////////////////////////////

  always_comb begin
    if (ld_active_i) begin
      ram_addr_o  = ld_addr_i;
      ram_wdata_o = ld_wdata_i;
      ram_wstrb_o = {soc_pkg::STRB_W{ld_we_i}};
      ram_rd_en_o = 1'b0;
    end else begin
      ram_addr_o  = addr_i[AW+1:2];
      ram_wdata_o = wdata_i;
      ram_wstrb_o = (valid_i && is_ram) ? wstrb_i : '0;
      ram_rd_en_o = valid_i && is_ram && (wstrb_i == '0);
    end
  end

  // Cycle timer, held at zero while the processor is in reset
  always_ff @(posedge clk_i) begin
    if (!rst_n || ld_active_i) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

endmodule

//--- hdl/ram_wait_gen.sv
`timescale 1ns/10ps

module ram_wait_gen #(
  parameter int RAM_DELAY = 16
) (
  input  logic clk_i,
  input  logic rst_n,
  input  logic req_i,
  input  logic done_i,
  output logic ready_o
);

  logic                 req_q;
  logic [RAM_DELAY-1:0] shift_q;

  if (RAM_DELAY < 2) begin : g_delay_check
    $error("ram_wait_gen needs RAM_DELAY of at least 2");
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      req_q   <= 1'b0;
      shift_q <= '0;
    end else begin
      req_q <= req_i;
      // Handshake flushes the pipe so ready is a single pulse
      if (done_i) begin
        shift_q <= '0;
      end else begin
        shift_q <= {shift_q[RAM_DELAY-2:0], req_q};
      end
    end
  end

  assign ready_o = shift_q[RAM_DELAY-1];

  a_ready_after_req : assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_o |-> $past(req_i));

endmodule

//--- hdl/main_ram.sv
`timescale 1ns/10ps

module main_ram #(
  parameter int RAM_DEPTH = 4096
) (
  input  logic                         clk_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  input  logic [soc_pkg::STRB_W-1:0]   wstrb_i,
  input  logic                         rd_en_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o
);

  logic [soc_pkg::DATA_W-1:0] mem_q [RAM_DEPTH];
  logic [soc_pkg::DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////
  // Byte-lane write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < soc_pkg::STRB_W; i++) begin
      if (wstrb_i[i]) begin
        mem_q[addr_i][i*soc_pkg::BYTE_W +: soc_pkg::BYTE_W] <=
          wdata_i[i*soc_pkg::BYTE_W +: soc_pkg::BYTE_W];
      end
    end
  end

  //////////////////////////////////////////////////
  // Registered read
  //////////////////////////////////////////////////

  // Output holds its last value between reads
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/prog_loader.sv
`timescale 1ns/10ps

module prog_loader #(
  parameter int RAM_DEPTH = 4096
) (
  input  logic                         clk_i,
  input  logic                         rst_n,
  input  logic [soc_pkg::BYTE_W-1:0]   byte_i,
  input  logic                         strobe_i,
  output logic                         active_o,
  output logic                         we_o,
  output logic [$clog2(RAM_DEPTH)-1:0] addr_o,
  output logic [soc_pkg::DATA_W-1:0]   wdata_o
);

  localparam int AW = $clog2(RAM_DEPTH);

  logic                       active_q;
  logic                       have_len_q;
  logic [1:0]                 byte_cnt_q;
  logic [soc_pkg::DATA_W-1:0] shift_q;
  logic [soc_pkg::DATA_W-1:0] words_left_q;
  // One spare bit so an overlong image shows up as an overflow
  logic [AW:0]                addr_q;
  logic                       we_q;
  logic [soc_pkg::DATA_W-1:0] wdata_q;
  logic [soc_pkg::DATA_W-1:0] word_next;
  logic                       word_done;

  // Little-endian packing, newest byte lands on top
  assign word_next = {byte_i, shift_q[soc_pkg::DATA_W-1:soc_pkg::BYTE_W]};
  assign word_done = strobe_i && (byte_cnt_q == 2'd3);

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      have_len_q   <= 1'b0;
      byte_cnt_q   <= '0;
      words_left_q <= '0;
      addr_q       <= '0;
      we_q         <= 1'b0;
    end else begin
      we_q <= 1'b0;
      if (strobe_i) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;
        active_q   <= 1'b1;
      end
      if (word_done) begin
        if (!have_len_q) begin
          // First word of the image is the word count
          words_left_q <= word_next;
          if (word_next == '0) begin
            active_q <= 1'b0;
          end else begin
            have_len_q <= 1'b1;
          end
        end else begin
          we_q <= 1'b1;
        end
      end
      if (we_q) begin
        addr_q       <= addr_q + 1'b1;
        words_left_q <= words_left_q - 1'b1;
        if (words_left_q == 1) begin
          active_q   <= 1'b0;
          have_len_q <= 1'b0;
          addr_q     <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (strobe_i) begin
      shift_q <= word_next;
    end
    if (word_done) begin
      wdata_q <= word_next;
    end
  end

  assign active_o = active_q;
  assign we_o     = we_q;
  assign addr_o   = addr_q[AW-1:0];
  assign wdata_o  = wdata_q;

  a_addr_in_range : assert property (@(posedge clk_i) disable iff (!rst_n)
    we_q |-> (addr_q < RAM_DEPTH));

  a_we_while_active : assert property (@(posedge clk_i) disable iff (!rst_n)
    we_o |-> active_o);

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                       clk_i,
  input  logic                       rst_n,
  input  logic                       rx_i,
  output logic [soc_pkg::BYTE_W-1:0] byte_o,
  output logic                       strobe_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e                  state_q;
  logic                       rx_meta_q;
  logic                       rx_sync_q;
  logic [CNT_W-1:0]           cnt_q;
  logic [2:0]                 bit_idx_q;
  logic [soc_pkg::BYTE_W-1:0] data_q;
  logic                       strobe_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      strobe_q  <= 1'b0;
    end else begin
      // Two-flop synchronizer on the serial pin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      strobe_q  <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Recheck at mid start bit, a glitch goes back to idle
          if (cnt_q == HALF_END) begin
            cnt_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == BIT_END) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          // Frame kept only with a valid stop bit
          if (cnt_q == BIT_END) begin
            strobe_q <= rx_sync_q;
            state_q  <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB first, sampled at mid-bit
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && cnt_q == BIT_END) begin
      data_q <= {rx_sync_q, data_q[soc_pkg::BYTE_W-1:1]};
    end
  end

  assign byte_o   = data_q;
  assign strobe_o = strobe_q;

endmodule

//--- hdl/soc_pkg.sv
package soc_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int BYTE_W = DATA_W / STRB_W;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Main memory window, offset bits masked off before compare
  localparam logic [ADDR_W-1:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK_ADDR = 32'h000f_ffff;

  // Free-running cycle timer, low and high words
  localparam logic [ADDR_W-1:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [ADDR_W-1:0] TIMER_HI_ADDR = 32'h3000_0004;

endpackage
